/* hw/pm_defs.svh */
`ifndef PM_DEFS_SVH
`define PM_DEFS_SVH

`define PM_ADR_BITS   8     // Program address bits, 256 words
`define PM_DAT_BITS   32    // Data and instruction word bits
`define PM_REGS       4     // General registers r0 to r3
`define PM_FIFO_DEPTH 4     // Output FIFO entries, power of two

`endif

/* hw/pm_pkg.sv */
`include "pm_defs.svh"

package pm_pkg;

    typedef logic [`PM_ADR_BITS-1:0]      pm_adr_t;      // Program address
    typedef logic [`PM_DAT_BITS-1:0]      pm_word_t;     // Data and instruction word
    typedef logic [$clog2(`PM_REGS)-1:0]  pm_reg_sel_t;  // Register index
    typedef logic [15:0]                  pm_imm_t;      // Immediate field

    // Unlisted codes execute as NOP
    typedef enum logic [3:0]
    {
        NOP  = 4'h0,
        LDI  = 4'h1,    // Zero-extended immediate load
        ADDI = 4'h2,    // Sign-extended immediate add
        ADD  = 4'h3,
        SUB  = 4'h4,
        XOR  = 4'h5,
        JNZ  = 4'h6,    // Jump when dst nonzero
        OUT  = 4'h7,    // Push dst to result FIFO
        HALT = 4'h8
    } pm_opcode_e;

    typedef enum logic [2:0]
    {
        IDLE,
        FETCH,          // Address on ROM
        DECODE,         // ROM data valid, latch instruction
        EXEC,
        PUSH            // Wait for FIFO space
    } pm_state_e;

    typedef struct packed
    {
        pm_opcode_e  opcode;    // Bits 31:28
        pm_reg_sel_t dst;       // Bits 27:26
        pm_reg_sel_t src;       // Bits 25:24
        logic [7:0]  rsvd;      // Bits 23:16, ignored
        pm_imm_t     imm;       // Bits 15:0
    } pm_instr_t;

    typedef struct packed
    {
        logic     first;        // First word of a program
        logic     last;         // Last word, triggers run
        pm_word_t dat;
    } pm_init_beat_t;

    typedef struct packed
    {
        logic     clr;          // Restart write pointer at zero
        logic     we;           // Write strobe
        pm_word_t dat;
    } pm_rom_wr_t;

endpackage

/* hw/pm_loader.sv */
`timescale 1ns/1ns

module pm_loader
(
    input  logic                  CLK_IN,
    input  logic                  reset,
    input  pm_pkg::pm_init_beat_t init_beat,    // Firmware beat from host
    input  logic                  init_valid,
    output logic                  init_ready,
    input  logic                  busy,         // Program running
    output pm_pkg::pm_rom_wr_t    rom_wr,       // ROM write command
    output logic                  start         // One-cycle run trigger
);

    logic accept;                               // Beat transfer this cycle

    // Host is held off while a program runs and during the start cycle
    assign init_ready = !busy && !start;
    assign accept     = init_valid && init_ready;

    // Write goes straight to the ROM on the accepting edge
    assign rom_wr.we  = accept;
    assign rom_wr.clr = accept && init_beat.first;  // New program from address 0
    assign rom_wr.dat = init_beat.dat;

    // Last beat seen, kick sequencer next cycle
    always_ff @(posedge CLK_IN)
    begin
        if (reset)
            start <= 1'b0;
        else
            start <= accept && init_beat.last;  // Single pulse, ready drops with it
    end

endmodule

/* hw/pm_rom.sv */
`timescale 1ns/1ns

`include "pm_defs.svh"

module pm_rom
(
    input  logic               CLK_IN,
    input  pm_pkg::pm_rom_wr_t rom_wr,      // Load port from loader
    input  pm_pkg::pm_adr_t    fetch_adr,   // Read address from sequencer
    output pm_pkg::pm_word_t   rom_dat      // Registered read data
);

    pm_pkg::pm_word_t mem [2**`PM_ADR_BITS];  // Program storage
    pm_pkg::pm_adr_t  wp;                     // Load write pointer
    pm_pkg::pm_adr_t  mem_adr;                // Shared port address

    // First beat lands at 0, pointer moves past it
    always_ff @(posedge CLK_IN)
    begin
        if (rom_wr.we)
        begin
            if (rom_wr.clr)
                wp <= pm_pkg::pm_adr_t'(1);
            else
                wp <= wp + pm_pkg::pm_adr_t'(1);
        end
    end

    // Write owns the port, fetch otherwise
    assign mem_adr = rom_wr.we ? (rom_wr.clr ? '0 : wp) : fetch_adr;

    // Single port, read-first, one cycle latency
    always_ff @(posedge CLK_IN)
    begin
        if (rom_wr.we)
            mem[mem_adr] <= rom_wr.dat;
        rom_dat <= mem[mem_adr];
    end

endmodule

/* hw/pm_sequencer.sv */
`timescale 1ns/1ns

`include "pm_defs.svh"

module pm_sequencer
(
    input  logic             CLK_IN,
    input  logic             reset,
    input  logic             start,         // Run trigger from loader
    output pm_pkg::pm_adr_t  fetch_adr,     // Program counter to ROM
    input  pm_pkg::pm_word_t rom_dat,       // Instruction one cycle later
    output pm_pkg::pm_word_t push_dat,      // OUT word to FIFO
    output logic             push_valid,
    input  logic             push_ready,
    output logic             busy
);

    pm_pkg::pm_state_e state;
    pm_pkg::pm_adr_t   pc;
    pm_pkg::pm_adr_t   next_pc;                 // PC after EXEC
    pm_pkg::pm_instr_t instr;                   // Latched in DECODE
    pm_pkg::pm_word_t  regs [`PM_REGS];         // r0 to r3
    pm_pkg::pm_word_t  dst_val;
    pm_pkg::pm_word_t  src_val;
    pm_pkg::pm_word_t  imm_sx;                  // Sign-extended immediate
    pm_pkg::pm_word_t  wb_val;                  // Write-back value
    logic              wb_en;

    assign fetch_adr  = pc;
    assign busy       = (state != pm_pkg::IDLE);
    assign push_valid = (state == pm_pkg::PUSH);
    assign push_dat   = regs[instr.dst];        // Stable while in PUSH

    assign dst_val = regs[instr.dst];
    assign src_val = regs[instr.src];
    assign imm_sx  = {{(`PM_DAT_BITS-16){instr.imm[15]}}, instr.imm};

    // ALU and branch decode
    always_comb
    begin
        wb_en   = 1'b0;
        wb_val  = dst_val;
        next_pc = pc + pm_pkg::pm_adr_t'(1);
        case (instr.opcode)
            pm_pkg::LDI:
            begin
                wb_en  = 1'b1;
                wb_val = pm_pkg::pm_word_t'(instr.imm);    // Zero-extend
            end
            pm_pkg::ADDI:
            begin
                wb_en  = 1'b1;
                wb_val = dst_val + imm_sx;
            end
            pm_pkg::ADD:
            begin
                wb_en  = 1'b1;
                wb_val = dst_val + src_val;
            end
            pm_pkg::SUB:
            begin
                wb_en  = 1'b1;
                wb_val = dst_val - src_val;
            end
            pm_pkg::XOR:
            begin
                wb_en  = 1'b1;
                wb_val = dst_val ^ src_val;
            end
            pm_pkg::JNZ:
            begin
                if (dst_val != '0)
                    next_pc = instr.imm[`PM_ADR_BITS-1:0];  // Low bits of target
            end
            default:
            begin
                wb_en = 1'b0;                           // NOP, OUT, HALT, unknown
            end
        endcase
    end

    // Control FSM
    always_ff @(posedge CLK_IN)
    begin
        if (reset)
        begin
            state <= pm_pkg::IDLE;
            pc    <= '0;
        end
        else
        begin
            case (state)
                pm_pkg::IDLE:
                begin
                    if (start)
                    begin
                        pc    <= '0;                    // Every run from address 0
                        state <= pm_pkg::FETCH;
                    end
                end
                pm_pkg::FETCH:
                    state <= pm_pkg::DECODE;
                pm_pkg::DECODE:
                    state <= pm_pkg::EXEC;
                pm_pkg::EXEC:
                begin
                    pc <= next_pc;
                    if (instr.opcode == pm_pkg::HALT)
                        state <= pm_pkg::IDLE;
                    else if (instr.opcode == pm_pkg::OUT)
                        state <= pm_pkg::PUSH;
                    else
                        state <= pm_pkg::FETCH;
                end
                pm_pkg::PUSH:
                begin
                    if (push_ready)
                        state <= pm_pkg::FETCH;         // Word taken by FIFO
                end
                default:
                    state <= pm_pkg::IDLE;
            endcase
        end
    end

    // Instruction latch
    always_ff @(posedge CLK_IN)
    begin
        if (state == pm_pkg::DECODE)
            instr <= pm_pkg::pm_instr_t'(rom_dat);
    end

    // Register file, cleared at run start
    always_ff @(posedge CLK_IN)
    begin
        if ((state == pm_pkg::IDLE) && start)
        begin
            for (int i = 0; i < `PM_REGS; i++)
                regs[i] <= '0;
        end
        else if ((state == pm_pkg::EXEC) && wb_en)
            regs[instr.dst] <= wb_val;
    end

endmodule

/* hw/pm_out_fifo.sv */
`timescale 1ns/1ns

`include "pm_defs.svh"

module pm_out_fifo
(
    input  logic             CLK_IN,
    input  logic             reset,
    input  pm_pkg::pm_word_t push_dat,      // From sequencer
    input  logic             push_valid,
    output logic             push_ready,    // Not full
    output pm_pkg::pm_word_t res_dat,       // Head of queue
    output logic             res_valid,     // Not empty
    input  logic             res_ready
);

    typedef logic [$clog2(`PM_FIFO_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(`PM_FIFO_DEPTH):0]   cnt_t;  // One extra bit for full

    pm_pkg::pm_word_t mem [`PM_FIFO_DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    cnt_t             cnt;                  // Occupancy
    logic             push;
    logic             pop;

    assign push_ready = (cnt != cnt_t'(`PM_FIFO_DEPTH));
    assign res_valid  = (cnt != '0);
    assign res_dat    = mem[rd_ptr];

    assign push = push_valid && push_ready;
    assign pop  = res_valid && res_ready;

    // Pointers and count
    always_ff @(posedge CLK_IN)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + ptr_t'(1);   // Wraps, depth is power of two
            if (pop)
                rd_ptr <= rd_ptr + ptr_t'(1);
            case ({push, pop})
                2'b10:   cnt <= cnt + cnt_t'(1);
                2'b01:   cnt <= cnt - cnt_t'(1);
                default: cnt <= cnt;            // Idle or simultaneous
            endcase
        end
    end

    // Storage
    always_ff @(posedge CLK_IN)
    begin
        if (push)
            mem[wr_ptr] <= push_dat;
    end

endmodule

/* hw/pm_top.sv */
`timescale 1ns/1ns

module pm_top
(
    input  logic                  CLK_IN,
    input  logic                  reset,
    input  pm_pkg::pm_init_beat_t init_beat,    // Firmware stream
    input  logic                  init_valid,
    output logic                  init_ready,
    output pm_pkg::pm_word_t      res_dat,      // Result stream
    output logic                  res_valid,
    input  logic                  res_ready,
    output logic                  busy          // Program running
);

    pm_pkg::pm_rom_wr_t rom_wr;
    pm_pkg::pm_adr_t    fetch_adr;
    pm_pkg::pm_word_t   rom_dat;
    pm_pkg::pm_word_t   push_dat;
    logic               push_valid;
    logic               push_ready;
    logic               start;

    // Input side
    pm_loader i_pm_loader
    (
        .CLK_IN     (CLK_IN),
        .reset      (reset),
        .init_beat  (init_beat),
        .init_valid (init_valid),
        .init_ready (init_ready),
        .busy       (busy),
        .rom_wr     (rom_wr),
        .start      (start)
    );

    pm_rom i_pm_rom
    (
        .CLK_IN     (CLK_IN),
        .rom_wr     (rom_wr),
        .fetch_adr  (fetch_adr),
        .rom_dat    (rom_dat)
    );

    pm_sequencer i_pm_sequencer
    (
        .CLK_IN     (CLK_IN),
        .reset      (reset),
        .start      (start),
        .fetch_adr  (fetch_adr),
        .rom_dat    (rom_dat),
        .push_dat   (push_dat),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .busy       (busy)
    );

    // Output side
    pm_out_fifo i_pm_out_fifo
    (
        .CLK_IN     (CLK_IN),
        .reset      (reset),
        .push_dat   (push_dat),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .res_dat    (res_dat),
        .res_valid  (res_valid),
        .res_ready  (res_ready)
    );

endmodule

/* verif/pm_chk.sv */
`timescale 1ns/1ns

module pm_chk
(
    input logic             CLK_IN,
    input logic             reset,
    input logic             init_ready,
    input logic             busy,
    input logic             res_valid,
    input logic             res_ready,
    input pm_pkg::pm_word_t res_dat
);

    int fail_cnt = 0;                          // Failed assertion count

    // Stalled result word holds
    res_hold: assert property (@(posedge CLK_IN) disable iff (reset)
        res_valid && !res_ready |=> $stable(res_dat))
    else
    begin
        fail_cnt++;
        $error("res_dat changed while res_valid was high and res_ready low");
    end

    // Host locked out during a run
    load_lock: assert property (@(posedge CLK_IN) disable iff (reset)
        busy |-> !init_ready)
    else
    begin
        fail_cnt++;
        $error("init_ready was high while a program was running");
    end

    idle_reset: assert property (@(posedge CLK_IN) reset |=> !busy)
    else
    begin
        fail_cnt++;
        $error("busy was high in the cycle after reset");
    end

endmodule

bind pm_top pm_chk i_pm_chk
(
    .CLK_IN     (CLK_IN),
    .reset      (reset),
    .init_ready (init_ready),
    .busy       (busy),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_dat    (res_dat)
);

/* verif/pm_tb.sv */
`timescale 1ns/1ns

`include "pm_defs.svh"

module pm_tb;

    logic                  CLK_IN = 1'b0;
    logic                  reset;
    pm_pkg::pm_init_beat_t init_beat;          // Firmware beat to loader
    logic                  init_valid;
    logic                  init_ready;
    pm_pkg::pm_word_t      res_dat;
    logic                  res_valid;
    logic                  res_ready = 1'b1;   // Result port back-pressure
    logic                  busy;

    pm_pkg::pm_word_t prog [$];                // Program being built
    pm_pkg::pm_word_t exp_q [$];               // Expected OUT words in order
    int               word_errs  = 0;
    int               flag_errs  = 0;
    int               other_errs = 0;
    int               cycles     = 0;
    int               limit      = 40;         // Reset margin that grows with each test
    int               run_cycles = 0;          // Busy length of the last modeled program
    bit               bp_on      = 1'b0;       // Random stalls on res_ready
    int               low_left   = 0;          // Rest of a long low stretch

    pm_top i_pm_top
    (
        .CLK_IN     (CLK_IN),
        .reset      (reset),
        .init_beat  (init_beat),
        .init_valid (init_valid),
        .init_ready (init_ready),
        .res_dat    (res_dat),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .busy       (busy)
    );

    always #2 CLK_IN = ~CLK_IN;                // 4 ns period

    function automatic pm_pkg::pm_word_t enc(pm_pkg::pm_opcode_e op, int dst, int src, int imm);
        pm_pkg::pm_instr_t ins;
        ins.opcode = op;
        ins.dst    = pm_pkg::pm_reg_sel_t'(dst);
        ins.src    = pm_pkg::pm_reg_sel_t'(src);
        ins.rsvd   = 8'($urandom);             // Unused field left random
        ins.imm    = pm_pkg::pm_imm_t'(imm);
        return pm_pkg::pm_word_t'(ins);
    endfunction

    // One of the five data instructions
    function automatic pm_pkg::pm_opcode_e pick_op();
        case ($urandom_range(0, 4))
            0:       return pm_pkg::LDI;
            1:       return pm_pkg::ADDI;
            2:       return pm_pkg::ADD;
            3:       return pm_pkg::SUB;
            default: return pm_pkg::XOR;
        endcase
    endfunction

    task automatic check_word(input pm_pkg::pm_word_t got, input pm_pkg::pm_word_t exp);
        if (got !== exp)
        begin
            word_errs++;
            $display("ERR res_dat got %h exp %h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flag_errs++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic gen_prog(input bit loops, input int pieces);
        int kind;
        int body_at;
        prog.delete();
        repeat (pieces)
        begin
            kind = $urandom_range(0, loops ? 5 : 3);
            case (kind)
                3: prog.push_back(enc(pm_pkg::OUT, $urandom_range(0, 3), 0, 0));
                4, 5:
                begin
                    prog.push_back(enc(pm_pkg::LDI, 3, 0, $urandom_range(1, 5)));  // Count
                    body_at = prog.size();
                    repeat ($urandom_range(1, 3))
                        prog.push_back(enc(pick_op(), $urandom_range(0, 2),
                                           $urandom_range(0, 3), $urandom));  // r3 untouched
                    prog.push_back(enc(pm_pkg::OUT, $urandom_range(0, 2), 0, 0));
                    prog.push_back(enc(pm_pkg::ADDI, 3, 0, 'hFFFF));   // Minus one
                    prog.push_back(enc(pm_pkg::JNZ, 3, 0, body_at));
                end
                default: prog.push_back(enc(pick_op(), $urandom_range(0, 3),
                                            $urandom_range(0, 3), $urandom));
            endcase
        end
        prog.push_back(enc(pm_pkg::HALT, 0, 0, 0));
    endtask

    // Instruction-set model that appends expected words and grows the cycle limit
    task automatic model_prog();
        pm_pkg::pm_word_t  r [`PM_REGS];
        pm_pkg::pm_instr_t ins;
        pm_pkg::pm_adr_t   pc;
        pm_pkg::pm_adr_t   nxt;
        int                steps;
        int                outs;
        bit                done;
        foreach (r[k])
            r[k] = '0;                         // Cleared at every run
        pc    = '0;
        steps = 0;
        outs  = 0;
        done  = 1'b0;
        while (!done && steps < 4096)
        begin
            ins = pm_pkg::pm_instr_t'(prog[pc]);
            nxt = pc + pm_pkg::pm_adr_t'(1);   // Wraps at 8 bits
            steps++;
            case (ins.opcode)
                pm_pkg::LDI:  r[ins.dst] = {16'h0, ins.imm};
                pm_pkg::ADDI: r[ins.dst] = r[ins.dst] + {{16{ins.imm[15]}}, ins.imm};
                pm_pkg::ADD:  r[ins.dst] = r[ins.dst] + r[ins.src];
                pm_pkg::SUB:  r[ins.dst] = r[ins.dst] - r[ins.src];
                pm_pkg::XOR:  r[ins.dst] = r[ins.dst] ^ r[ins.src];
                pm_pkg::JNZ:
                begin
                    if (r[ins.dst] != '0)
                        nxt = pm_pkg::pm_adr_t'(ins.imm);
                end
                pm_pkg::OUT:
                begin
                    exp_q.push_back(r[ins.dst]);
                    outs++;
                end
                pm_pkg::HALT: done = 1'b1;
                default:      ;                // NOP and unknown codes
            endcase
            pc = nxt;
        end
        if (!done)
        begin
            other_errs++;
            $display("Model did not reach HALT within 4096 instructions");
        end
        run_cycles = 3 * steps + outs;                  // One PUSH cycle per OUT
        limit += 3 * (steps + 10) * 4 + prog.size();    // Three cycles each with a slack of 4
    endtask

    // Entered and left on a falling edge with valid kept up when keep is set
    task automatic load_prog(input pm_pkg::pm_word_t p [$], input bit keep, output int stall);
        pm_pkg::pm_init_beat_t beat;
        stall = 0;
        foreach (p[i])
        begin
            beat.first = (i == 0);
            beat.last  = (i == p.size() - 1);
            beat.dat   = p[i];
            init_beat  = beat;
            init_valid = 1'b1;
            while (!init_ready)
            begin
                stall++;
                @(negedge CLK_IN);
            end
            check_flag("busy", busy, 1'b0);    // No load under a running program
            @(negedge CLK_IN);                 // Transfer on the rising edge between
        end
        if (!keep)
            init_valid = 1'b0;
    endtask

    // Busy length is fixed by the instruction mix when the FIFO never fills
    task automatic wait_done();
        int busy_len;
        while (!busy)
            @(negedge CLK_IN);                 // Start cycle first
        busy_len = 0;
        while (busy)
        begin
            busy_len++;
            @(negedge CLK_IN);
        end
        if (!bp_on && busy_len != run_cycles)
        begin
            other_errs++;
            $display("Program kept busy high for %0d cycles where the model expects %0d",
                     busy_len, run_cycles);
        end
        while (exp_q.size() != 0)
            @(negedge CLK_IN);                 // FIFO drain
        check_flag("res_valid", res_valid, 1'b0);   // Nothing extra left
    endtask

    task automatic run_prog(input bit loops, input int pieces);
        int stall;
        gen_prog(loops, pieces);
        model_prog();
        load_prog(prog, 1'b0, stall);
        wait_done();
    endtask

    // Second program waits on the bus through the whole first run
    task automatic run_pair();
        pm_pkg::pm_word_t first_p [$];
        int               stall;
        gen_prog(1'b1, 8);
        model_prog();
        first_p = prog;
        gen_prog(1'b1, 8);
        model_prog();
        load_prog(first_p, 1'b1, stall);
        load_prog(prog, 1'b0, stall);
        if (stall < 3)
        begin
            other_errs++;
            $display("Second load was not held off while the first program ran");
        end
        wait_done();
    endtask

    // Result monitor with one expected word per transfer
    always @(posedge CLK_IN)
    begin
        if (!reset && res_valid && res_ready)
        begin
            if (exp_q.size() == 0)
            begin
                other_errs++;
                $display("Result word %h arrived when none was expected", res_dat);
            end
            else
                check_word(res_dat, exp_q.pop_front());
        end
    end

    // Random toggling with occasional long low stretches
    always @(negedge CLK_IN)
    begin
        if (!bp_on)
            res_ready = 1'b1;
        else if (low_left > 0)
        begin
            res_ready = 1'b0;
            low_left--;
        end
        else if ($urandom_range(0, 15) == 0)
        begin
            res_ready = 1'b0;
            low_left  = $urandom_range(8, 23);
        end
        else
            res_ready = ($urandom_range(0, 1) != 0);
    end

    always @(posedge CLK_IN)
    begin
        cycles++;
        if (cycles >= limit)
        begin
            $display("Run stopped after %0d cycles, the cycle limit was reached", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(39));
        reset      = 1'b1;
        init_valid = 1'b0;
        init_beat  = '0;
        repeat (5)
            @(negedge CLK_IN);
        reset = 1'b0;
        @(negedge CLK_IN);
        check_flag("busy", busy, 1'b0);
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("init_ready", init_ready, 1'b1);
        repeat (3)
            run_prog(1'b0, 12);                // Straight-line arithmetic
        repeat (3)
            run_prog(1'b1, 10);                // Counted loops
        bp_on = 1'b1;
        repeat (3)
            run_prog(1'b1, 12);
        run_pair();
        repeat (8)
        begin
            bp_on = ($urandom_range(0, 1) != 0);
            run_prog($urandom_range(0, 1) != 0, $urandom_range(1, 30));
        end
        $display("Errors: res_dat %0d, flags %0d, other %0d, assertions %0d",
                 word_errs, flag_errs, other_errs, i_pm_top.i_pm_chk.fail_cnt);
        if (word_errs + flag_errs + other_errs + i_pm_top.i_pm_chk.fail_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/pm_pkg.sv
hw/pm_loader.sv
hw/pm_rom.sv
hw/pm_sequencer.sv
hw/pm_out_fifo.sv
hw/pm_top.sv
verif/pm_chk.sv
verif/pm_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pm_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vpm_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
